//--- dv/cpuAsserts.sv
`timescale 1ns/1ps
`default_nettype none

module cpuAsserts (
	input wire clk,
	input wire reset_n,
	input wire readM,
	input wire writeM,
	input wire cpuPkg::word_t address,
	input wire cpuPkg::word_t writeData,
	input wire cpuPkg::word_t outputPort,
	input wire outputValid,
	input wire halted
);

	// one memory strobe at a time
	noReadWithWrite: assert property (@(posedge clk) disable iff (!reset_n)
		!(readM && writeM))
		else $error("readM and writeM asserted in the same cycle");

	// only reset leaves the halted state
	haltIsSticky: assert property (@(posedge clk) disable iff (!reset_n)
		halted |=> halted)
		else $error("halted dropped without reset");

	quietWhenHalted: assert property (@(posedge clk) disable iff (!reset_n)
		halted |-> (!readM && !writeM && !outputValid))
		else $error("bus or output activity after halt");

	// WWD is a single-cycle pulse
	outputPulseWidth: assert property (@(posedge clk) disable iff (!reset_n)
		outputValid |=> !outputValid)
		else $error("outputValid held for more than one cycle");

	outputKnown: assert property (@(posedge clk) disable iff (!reset_n)
		outputValid |-> !$isunknown(outputPort))
		else $error("outputPort unknown while outputValid is high");

	storeKnown: assert property (@(posedge clk) disable iff (!reset_n)
		writeM |-> (!$isunknown(address) && !$isunknown(writeData)))
		else $error("store address or data unknown");

endmodule

`default_nettype wire

//--- dv/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
	import cpuPkg::*;

	localparam word_t resetVec = 16'h0010;
	localparam int wwdCount = 18;
	localparam int storeCount = 2;
	localparam int haltTimeout = 2000;

	typedef struct packed {
		word_t addr;
		word_t data;
	} storePair_t;

	logic clk = 1'b0;
	logic reset_n;
	word_t readData = '0;
	logic readM;
	logic writeM;
	word_t address;
	word_t writeData;
	word_t outputPort;
	logic outputValid;
	logic halted;

	word_t mem [256];
	logic rdPending = 1'b0;
	logic [7:0] rdAddr = '0;
	logic haltSeen = 1'b0;
	int wwdIdx = 0;
	int storeIdx = 0;

	// worked out by hand from the program below
	word_t expWwd [wwdCount] = '{16'h0003, 16'h0009, 16'h0004, 16'hFFFF, 16'hFFF9,
		16'hFFFA, 16'h000C, 16'hFFFE, 16'h1284, 16'h1280, 16'h7E31, 16'hFFFD,
		16'h0006, 16'hFFFD, 16'h0006, 16'hFFFD, 16'h0040, 16'h0042};
	storePair_t expStore [storeCount] = '{'{16'h0070, 16'h1280}, '{16'h0071, 16'hFFFD}};

	always #5 clk = ~clk;

	cpuTop #(
		.resetVector(resetVec)
	) UUT (
		.clk(clk),
		.reset_n(reset_n),
		.readData(readData),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.writeData(writeData),
		.outputPort(outputPort),
		.outputValid(outputValid),
		.halted(halted)
	);

	bind cpuTop cpuAsserts assertChecks (
		.clk(clk),
		.reset_n(reset_n),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.writeData(writeData),
		.outputPort(outputPort),
		.outputValid(outputValid),
		.halted(halted)
	);

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic reportMismatch(input string what, input word_t got, input word_t expected);
		abortRun($sformatf("Mismatch at %0t ns: %s got %h, expected %h",
			$time, what, got, expected));
	endtask

	function automatic word_t rType(input regIdx_t rs, input regIdx_t rt, input regIdx_t rd,
			input logic [5:0] fn);
		return {4'hF, rs, rt, rd, fn};
	endfunction

	function automatic word_t iType(input logic [3:0] op, input regIdx_t rs, input regIdx_t rt,
			input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jType(input logic [3:0] op, input logic [11:0] target);
		return {op, target};
	endfunction

	// memory model: request taken at the rising edge, data driven at the falling edge
	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = {8'hC3 ^ 8'(i), 8'(i)};
		end
		// r1 = 6, r3 = -3, then one R-type op per WWD
		mem[8'h10] = iType(opAdi, 2'd0, 2'd1, 8'h06);
		mem[8'h11] = iType(opAdi, 2'd0, 2'd3, 8'hFD);
		mem[8'h12] = rType(2'd1, 2'd3, 2'd0, fnAdd);
		mem[8'h13] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		mem[8'h14] = rType(2'd1, 2'd3, 2'd0, fnSub);
		mem[8'h15] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		mem[8'h16] = rType(2'd1, 2'd3, 2'd0, fnAnd);
		mem[8'h17] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		mem[8'h18] = rType(2'd1, 2'd3, 2'd0, fnOrr);
		mem[8'h19] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		mem[8'h1A] = rType(2'd1, 2'd0, 2'd0, fnNot);
		mem[8'h1B] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		mem[8'h1C] = rType(2'd1, 2'd0, 2'd0, fnTcp);
		mem[8'h1D] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		mem[8'h1E] = rType(2'd1, 2'd0, 2'd0, fnShl);
		mem[8'h1F] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		mem[8'h20] = rType(2'd3, 2'd0, 2'd0, fnShr);
		mem[8'h21] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		// immediates, ORI must zero-extend
		mem[8'h22] = iType(opLhi, 2'd0, 2'd0, 8'h12);
		mem[8'h23] = iType(opOri, 2'd0, 2'd0, 8'h84);
		mem[8'h24] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		mem[8'h25] = iType(opAdi, 2'd0, 2'd0, 8'hFC);
		mem[8'h26] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		// stores to 0x70/0x71, then load a preloaded word and a stored one
		mem[8'h27] = iType(opSwd, 2'd1, 2'd0, 8'h6A);
		mem[8'h28] = iType(opSwd, 2'd1, 2'd3, 8'h6B);
		mem[8'h29] = iType(opLwd, 2'd1, 2'd0, 8'h6C);
		mem[8'h2A] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		mem[8'h2B] = iType(opLwd, 2'd1, 2'd0, 8'h6B);
		mem[8'h2C] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		// branch pairs; WWD r2 (zero) only on a wrong path
		mem[8'h2D] = iType(opBne, 2'd0, 2'd3, 8'h01);
		mem[8'h2E] = rType(2'd1, 2'd0, 2'd0, fnWwd);
		mem[8'h2F] = iType(opBne, 2'd0, 2'd1, 8'h01);
		mem[8'h30] = rType(2'd2, 2'd0, 2'd0, fnWwd);
		mem[8'h31] = iType(opBeq, 2'd0, 2'd3, 8'h01);
		mem[8'h32] = rType(2'd2, 2'd0, 2'd0, fnWwd);
		mem[8'h33] = iType(opBeq, 2'd0, 2'd1, 8'h01);
		mem[8'h34] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		mem[8'h35] = iType(opBgz, 2'd1, 2'd0, 8'h01);
		mem[8'h36] = rType(2'd2, 2'd0, 2'd0, fnWwd);
		mem[8'h37] = iType(opBgz, 2'd2, 2'd0, 8'h01);
		mem[8'h38] = rType(2'd1, 2'd0, 2'd0, fnWwd);
		mem[8'h39] = iType(opBlz, 2'd0, 2'd0, 8'h01);
		mem[8'h3A] = rType(2'd2, 2'd0, 2'd0, fnWwd);
		mem[8'h3B] = iType(opBlz, 2'd2, 2'd0, 8'h01);
		mem[8'h3C] = rType(2'd0, 2'd0, 2'd0, fnWwd);
		// jumps and the two small subroutines
		mem[8'h3D] = jType(opJmp, 12'h03F);
		mem[8'h3E] = rType(2'd2, 2'd0, 2'd0, fnWwd);
		mem[8'h3F] = jType(opJal, 12'h050);
		mem[8'h40] = iType(opOri, 2'd2, 2'd1, 8'h18);
		mem[8'h41] = rType(2'd1, 2'd0, 2'd0, fnJrl);
		mem[8'h42] = rType(2'd0, 2'd0, 2'd0, fnHlt);
		mem[8'h50] = rType(2'd2, 2'd0, 2'd0, fnWwd);
		mem[8'h51] = rType(2'd2, 2'd0, 2'd0, fnJpr);
		mem[8'h58] = rType(2'd2, 2'd0, 2'd0, fnWwd);
		mem[8'h59] = rType(2'd2, 2'd0, 2'd0, fnJpr);
		mem[8'h72] = 16'h7E31;
		forever begin
			@(posedge clk);
			rdPending = readM;
			rdAddr = address[7:0];
			if (writeM) begin
				mem[address[7:0]] = writeData;
			end
		end
	end

	always @(negedge clk) begin
		if (rdPending) begin
			readData <= mem[rdAddr];
		end
	end

	// checks on every rising edge, outputs are still the pre-edge values
	always @(posedge clk) begin
		if (reset_n) begin
			assert (!(readM && writeM))
				else abortRun("readM and writeM were high in the same cycle");
			if (haltSeen) begin
				assert (halted && !readM && !writeM && !outputValid)
					else abortRun("halted dropped or the bus was active after halt");
			end
			if (outputValid) begin
				assert (wwdIdx < wwdCount)
					else abortRun("more WWD outputs than the program produces");
				assert (outputPort == expWwd[wwdIdx])
					else reportMismatch($sformatf("WWD #%0d", wwdIdx), outputPort,
						expWwd[wwdIdx]);
				wwdIdx++;
			end
			if (writeM) begin
				assert (storeIdx < storeCount)
					else abortRun("more stores than the program performs");
				assert (address == expStore[storeIdx].addr)
					else reportMismatch($sformatf("store #%0d address", storeIdx), address,
						expStore[storeIdx].addr);
				assert (writeData == expStore[storeIdx].data)
					else reportMismatch($sformatf("store #%0d data", storeIdx), writeData,
						expStore[storeIdx].data);
				storeIdx++;
			end
			if (halted) begin
				haltSeen = 1'b1;
			end
		end
	end

	initial begin
		int cycles;
		reset_n = 1'b0;
		repeat (16) @(posedge clk);
		assert (!writeM && !outputValid && !halted)
			else abortRun("writeM, outputValid or halted high during reset");
		@(negedge clk);
		reset_n = 1'b1;
		@(posedge clk);
		assert (readM)
			else abortRun("no instruction fetch in the first cycle after reset");
		assert (address == resetVec)
			else reportMismatch("first fetch address", address, resetVec);
		cycles = 0;
		while (!halted && cycles < haltTimeout) begin
			@(posedge clk);
			cycles++;
		end
		if (!halted) begin
			abortRun("timed out waiting for the core to halt");
		end else begin
			// stay a while to see that the core keeps quiet
			repeat (8) @(posedge clk);
			if (wwdIdx == wwdCount && storeIdx == storeCount) begin
				$display("Finished with no errors");
				$finish;
			end else begin
				abortRun($sformatf("halted after %0d of %0d outputs and %0d of %0d stores",
					wwdIdx, wwdCount, storeIdx, storeCount));
			end
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module cpuTb -f src.f -o cpuSim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/cpuSim > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- src.f
src/cpuPkg.sv
src/alu.sv
src/registerFile.sv
src/controlUnit.sv
src/datapath.sv
src/cpuTop.sv
dv/cpuAsserts.sv
dv/cpuTb.sv

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire cpuPkg::word_t a,
	input wire cpuPkg::word_t b,
	input wire cpuPkg::aluOp_e op,
	output cpuPkg::word_t result
);
	import cpuPkg::*;

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			// unary ops work on a only
			aluNot: result = ~a;
			aluTwosComp: result = ~a + word_t'(1);
			aluShl: result = {a[wordSize-2:0], 1'b0};
			// sign bit is kept
			aluShr: result = {a[wordSize-1], a[wordSize-1:1]};
			aluPassB: result = b;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input wire clk,
	input wire reset_n,
	input wire cpuPkg::instrFields_t fields,
	output cpuPkg::ctrl_t ctrl,
	output logic halted
);
	import cpuPkg::*;

	microState_e state;
	microState_e stateNext;
	ctrl_t dec;
	logic isHalt;

	// R-type function codes 0..7 map onto the ALU operations
	function automatic aluOp_e functToAluOp(input funct_e fn);
		case (fn)
			fnSub: return aluSub;
			fnAnd: return aluAnd;
			fnOrr: return aluOr;
			fnNot: return aluNot;
			fnTcp: return aluTwosComp;
			fnShl: return aluShl;
			fnShr: return aluShr;
			default: return aluAdd;
		endcase
	endfunction

	// instruction decode, independent of the micro-state
	always_comb begin
		dec = '0;
		dec.aluOp = aluAdd;
		isHalt = 1'b0;
		case (fields.opcode)
			opBne, opBeq, opBgz, opBlz: begin
				// target is PC+1 plus the offset
				dec.aluSrcPc = 1'b1;
				dec.aluSrcImm = 1'b1;
				dec.branch = 1'b1;
			end
			opAdi: begin
				dec.aluSrcImm = 1'b1;
				dec.regWrite = 1'b1;
			end
			opOri: begin
				dec.aluOp = aluOr;
				dec.aluSrcImm = 1'b1;
				dec.regWrite = 1'b1;
			end
			opLhi: begin
				dec.aluOp = aluPassB;
				dec.aluSrcImm = 1'b1;
				dec.regWrite = 1'b1;
			end
			opLwd: begin
				dec.aluSrcImm = 1'b1;
				dec.memRead = 1'b1;
				dec.memToReg = 1'b1;
				dec.regWrite = 1'b1;
			end
			opSwd: begin
				dec.aluSrcImm = 1'b1;
				dec.memWrite = 1'b1;
			end
			opJmp: dec.jump = 1'b1;
			opJal: begin
				dec.jump = 1'b1;
				dec.linkToReg = 1'b1;
				dec.regWrite = 1'b1;
			end
			opRtype: begin
				case (fields.funct)
					fnAdd, fnSub, fnAnd, fnOrr, fnNot, fnTcp, fnShl, fnShr: begin
						dec.aluOp = functToAluOp(fields.funct);
						dec.regDst = 1'b1;
						dec.regWrite = 1'b1;
					end
					fnWwd: dec.wwd = 1'b1;
					fnJpr: dec.jumpReg = 1'b1;
					fnJrl: begin
						dec.jumpReg = 1'b1;
						dec.linkToReg = 1'b1;
						dec.regWrite = 1'b1;
					end
					fnHlt: isHalt = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	always_comb begin
		stateNext = state;
		case (state)
			stFetch1: stateNext = stFetch2;
			stFetch2: stateNext = stDecode;
			stDecode: stateNext = isHalt ? stHalted : stExecute;
			stExecute: begin
				if (dec.memRead || dec.memWrite) begin
					stateNext = stMem1;
				end else if (dec.regWrite) begin
					stateNext = stWriteback;
				end else begin
					stateNext = stFetch1;
				end
			end
			// stores finish here, loads go on to capture
			stMem1: stateNext = dec.memRead ? stMem2 : stFetch1;
			stMem2: stateNext = stWriteback;
			stWriteback: stateNext = stFetch1;
			default: stateNext = stHalted;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= stFetch1;
		end else begin
			state <= stateNext;
		end
	end

	// strobes and register writes only in the state that owns them
	always_comb begin
		ctrl = dec;
		ctrl.microState = state;
		ctrl.memRead = dec.memRead && (state == stMem1);
		ctrl.memWrite = dec.memWrite && (state == stMem1);
		ctrl.regWrite = dec.regWrite && (state == stWriteback);
		ctrl.wwd = dec.wwd && (state == stExecute);
		ctrl.branch = dec.branch && (state == stExecute);
		ctrl.jump = dec.jump && (state == stExecute);
		ctrl.jumpReg = dec.jumpReg && (state == stExecute);
		if (state == stFetch1 || state == stFetch2) begin
			ctrl.aluOp = aluAdd;
		end
	end

	assign halted = (state == stHalted);

endmodule

`default_nettype wire

//--- src/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int wordSize = 16;

	typedef logic [wordSize-1:0] word_t;
	typedef logic [1:0] regIdx_t;

	// primary opcode, instruction bits [15:12]
	typedef enum logic [3:0] {
		opBne = 4'd0,
		opBeq = 4'd1,
		opBgz = 4'd2,
		opBlz = 4'd3,
		opAdi = 4'd4,
		opOri = 4'd5,
		opLhi = 4'd6,
		opLwd = 4'd7,
		opSwd = 4'd8,
		opJmp = 4'd9,
		opJal = 4'd10,
		opRtype = 4'd15
	} opcode_e;

	// function code of the R-type group, bits [5:0]
	typedef enum logic [5:0] {
		fnAdd = 6'd0,
		fnSub = 6'd1,
		fnAnd = 6'd2,
		fnOrr = 6'd3,
		fnNot = 6'd4,
		fnTcp = 6'd5,
		fnShl = 6'd6,
		fnShr = 6'd7,
		fnJpr = 6'd25,
		fnJrl = 6'd26,
		fnWwd = 6'd28,
		fnHlt = 6'd29
	} funct_e;

	typedef enum logic [2:0] {
		stFetch1,
		stFetch2,
		stDecode,
		stExecute,
		stMem1,
		stMem2,
		stWriteback,
		stHalted
	} microState_e;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNot,
		aluTwosComp,
		aluShl,
		aluShr,
		aluPassB
	} aluOp_e;

	typedef struct packed {
		microState_e microState;
		aluOp_e aluOp;
		logic aluSrcImm;
		logic aluSrcPc;
		logic regDst;
		logic regWrite;
		logic memToReg;
		logic linkToReg;
		logic memRead;
		logic memWrite;
		logic branch;
		logic jump;
		logic jumpReg;
		logic wwd;
	} ctrl_t;

	typedef struct packed {
		opcode_e opcode;
		funct_e funct;
	} instrFields_t;

endpackage

`default_nettype wire

//--- src/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
	parameter cpuPkg::word_t resetVector = 16'h0000
) (
	input wire clk,
	input wire reset_n,
	input wire cpuPkg::word_t readData,
	output logic readM,
	output logic writeM,
	output cpuPkg::word_t address,
	output cpuPkg::word_t writeData,
	output cpuPkg::word_t outputPort,
	output logic outputValid,
	output logic halted
);
	import cpuPkg::*;

	ctrl_t ctrl;
	instrFields_t fields;

	controlUnit ctrlUnit (
		.clk(clk),
		.reset_n(reset_n),
		.fields(fields),
		.ctrl(ctrl),
		.halted(halted)
	);

	datapath #(
		.resetVector(resetVector)
	) dp (
		.clk(clk),
		.reset_n(reset_n),
		.ctrl(ctrl),
		.readData(readData),
		.fields(fields),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.writeData(writeData),
		.outputPort(outputPort),
		.outputValid(outputValid)
	);

endmodule

`default_nettype wire

//--- src/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
	parameter cpuPkg::word_t resetVector = 16'h0000
) (
	input wire clk,
	input wire reset_n,
	input wire cpuPkg::ctrl_t ctrl,
	input wire cpuPkg::word_t readData,
	output cpuPkg::instrFields_t fields,
	output logic readM,
	output logic writeM,
	output cpuPkg::word_t address,
	output cpuPkg::word_t writeData,
	output cpuPkg::word_t outputPort,
	output logic outputValid
);
	import cpuPkg::*;

	// JAL and JRL always link into r2
	localparam regIdx_t linkReg = 2'd2;

	word_t pc;
	word_t nextPc;
	word_t ir;
	word_t mdr;
	word_t rsValue;
	word_t rtValue;
	word_t immValue;
	word_t aluA;
	word_t aluB;
	word_t aluResult;
	word_t regWriteData;
	regIdx_t rs;
	regIdx_t rt;
	regIdx_t rd;
	regIdx_t regWriteAddr;
	logic inFetch1;
	logic inFetch2;
	logic branchCond;
	logic takeBranch;

	assign inFetch1 = (ctrl.microState == stFetch1);
	assign inFetch2 = (ctrl.microState == stFetch2);

	assign rs = ir[11:10];
	assign rt = ir[9:8];
	assign rd = ir[7:6];
	assign fields = '{opcode: opcode_e'(ir[15:12]), funct: funct_e'(ir[5:0])};

	// immediate shape follows the decoded ALU operation
	always_comb begin
		case (ctrl.aluOp)
			aluPassB: immValue = {ir[7:0], 8'h00};
			aluOr: immValue = {8'h00, ir[7:0]};
			default: immValue = {{(wordSize - 8){ir[7]}}, ir[7:0]};
		endcase
	end

	// fetch2 reuses the ALU for PC+1
	assign aluA = inFetch2 ? pc : (ctrl.aluSrcPc ? nextPc : rsValue);
	assign aluB = inFetch2 ? word_t'(1) : (ctrl.aluSrcImm ? immValue : rtValue);

	// branch opcodes 0..3 select the compare through their low bits
	always_comb begin
		case (ir[13:12])
			2'd0: branchCond = (rsValue != rtValue);
			2'd1: branchCond = (rsValue == rtValue);
			2'd2: branchCond = ($signed(rsValue) > 16'sd0);
			default: branchCond = ($signed(rsValue) < 16'sd0);
		endcase
	end

	assign takeBranch = ctrl.branch && branchCond;

	// nextPc keeps PC+1 for the link write after a jump
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= resetVector;
			nextPc <= resetVector;
		end else if (inFetch2) begin
			pc <= aluResult;
			nextPc <= aluResult;
		end else if (takeBranch) begin
			pc <= aluResult;
		end else if (ctrl.jump) begin
			pc <= {nextPc[wordSize-1:12], ir[11:0]};
		end else if (ctrl.jumpReg) begin
			pc <= rsValue;
		end
	end

	always_ff @(posedge clk) begin
		if (inFetch2) begin
			ir <= readData;
		end
		if (ctrl.microState == stMem2) begin
			mdr <= readData;
		end
	end

	assign regWriteAddr = ctrl.linkToReg ? linkReg : (ctrl.regDst ? rd : rt);

	always_comb begin
		if (ctrl.linkToReg) begin
			regWriteData = nextPc;
		end else if (ctrl.memToReg) begin
			regWriteData = mdr;
		end else begin
			regWriteData = aluResult;
		end
	end

	// memory side
	assign readM = inFetch1 || ctrl.memRead;
	assign writeM = ctrl.memWrite;
	assign address = inFetch1 ? pc : aluResult;
	assign writeData = rtValue;

	assign outputPort = rsValue;
	assign outputValid = ctrl.wwd;

	registerFile regs (
		.clk(clk),
		.reset_n(reset_n),
		.readAddr1(rs),
		.readAddr2(rt),
		.writeAddr(regWriteAddr),
		.writeData(regWriteData),
		.writeEnable(ctrl.regWrite),
		.readData1(rsValue),
		.readData2(rtValue)
	);

	alu aluUnit (
		.a(aluA),
		.b(aluB),
		.op(ctrl.aluOp),
		.result(aluResult)
	);

endmodule

`default_nettype wire

//--- src/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input wire clk,
	input wire reset_n,
	input wire cpuPkg::regIdx_t readAddr1,
	input wire cpuPkg::regIdx_t readAddr2,
	input wire cpuPkg::regIdx_t writeAddr,
	input wire cpuPkg::word_t writeData,
	input wire writeEnable,
	output cpuPkg::word_t readData1,
	output cpuPkg::word_t readData2
);
	import cpuPkg::*;

	word_t regs [4];

	// one write port, taken at the clock edge
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeData;
		end
	end

	// reads are asynchronous
	assign readData1 = regs[readAddr1];
	assign readData2 = regs[readAddr2];

endmodule

`default_nettype wire
